//--- proto_pkg.sv
package proto_pkg;

    // ========================================================================
    // command frame: SOF, cmd, three payload bytes, xor checksum
    // ========================================================================
    localparam logic [7:0] SOF_BYTE     = 8'hAA;
    localparam int         FRAME_LEN    = 6;

    localparam logic [7:0] CMD_PWM_DUTY   = 8'h01;
    localparam logic [7:0] CMD_PWM_PERIOD = 8'h02;
    localparam logic [7:0] CMD_STATUS     = 8'h03;

    // ========================================================================
    // reply: SOF, cmd, status, xor of cmd and status
    // ========================================================================
    localparam logic [7:0] RSP_SOF_BYTE = 8'h55;

    localparam logic [7:0] ST_OK      = 8'h00;
    localparam logic [7:0] ST_BAD_CMD = 8'h01;
    localparam logic [7:0] ST_BAD_SUM = 8'hEE;

    // reply queue entries
    localparam int RSP_DEPTH = 4;
    localparam int RSP_PTR_W = $clog2(RSP_DEPTH);

    // payload as seen by a duty command
    typedef struct packed {
        logic [7:0]  channel;
        logic [15:0] duty;
    } duty_view_t;

    // payload as seen by a period command
    typedef struct packed {
        logic [7:0]  prescale;
        logic [15:0] period;
    } period_view_t;

    typedef union packed {
        duty_view_t   duty_cfg;
        period_view_t period_cfg;
        logic [23:0]  raw;
    } cmd_payload_u;

endpackage

//--- pwm_pkg.sv
package pwm_pkg;

    // channels in the bank
    localparam int N_CH = 8;

    // period and duty counter width
    localparam int CNT_W = 16;

    // prescaler width
    localparam int PRE_W = 8;

endpackage

//--- cmd_frame_parser.sv
`timescale 1ns/1ps

module cmd_frame_parser (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic [7:0]             usb_data_i,
    input  logic                   usb_data_valid_i,
    output logic                   frame_valid_o,
    output logic [7:0]             frame_cmd_o,
    output proto_pkg::cmd_payload_u frame_payload_o,
    output logic                   frame_sum_ok_o
);

    // position of the next byte inside the frame, 0 means hunting for SOF
    logic [2:0] byte_pos;
    logic [7:0] sum_acc;

    localparam logic [2:0] LAST_POS = 3'(proto_pkg::FRAME_LEN - 1);

    // ========================================================================
    // byte position tracking
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            byte_pos      <= 3'd0;
            frame_valid_o <= 1'b0;
        end else begin
            frame_valid_o <= 1'b0;
            if (usb_data_valid_i) begin
                case (byte_pos)
                    3'd0: begin
                        // anything but SOF is dropped while idle
                        if (usb_data_i == proto_pkg::SOF_BYTE) begin
                            byte_pos <= 3'd1;
                        end
                    end
                    LAST_POS: begin
                        frame_valid_o <= 1'b1;
                        byte_pos      <= 3'd0;
                    end
                    default: begin
                        byte_pos <= byte_pos + 3'd1;
                    end
                endcase
            end
        end
    end

    // ========================================================================
    // field capture and checksum
    // ========================================================================
    always_ff @(posedge clk) begin
        if (usb_data_valid_i) begin
            case (byte_pos)
                3'd1: begin
                    frame_cmd_o <= usb_data_i;
                    sum_acc     <= usb_data_i;
                end
                3'd2, 3'd3, 3'd4: begin
                    // payload arrives msb first
                    frame_payload_o.raw <= {frame_payload_o.raw[15:0], usb_data_i};
                    sum_acc             <= sum_acc ^ usb_data_i;
                end
                LAST_POS: begin
                    frame_sum_ok_o <= (sum_acc == usb_data_i);
                end
                default: ;
            endcase
        end
    end

endmodule

//--- cmd_dispatch.sv
`timescale 1ns/1ps

module cmd_dispatch (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    frame_valid_i,
    input  logic [7:0]              frame_cmd_i,
    input  proto_pkg::cmd_payload_u frame_payload_i,
    input  logic                    frame_sum_ok_i,
    input  logic                    rsp_full_i,
    output logic                    cfg_we_o,
    output logic                    cfg_sel_o,
    output proto_pkg::cmd_payload_u cfg_payload_o,
    output logic                    rsp_push_o,
    output logic [7:0]              rsp_cmd_o,
    output logic [7:0]              rsp_status_o
);

    logic       we_d;
    logic       sel_d;
    logic       stat_rd;
    logic [7:0] status_d;
    logic [7:0] lost_cnt;
    logic       drop;

    // ========================================================================
    // command decode
    // ========================================================================
    always_comb begin
        we_d     = 1'b0;
        sel_d    = 1'b0;
        stat_rd  = 1'b0;
        status_d = proto_pkg::ST_OK;
        if (!frame_sum_ok_i) begin
            status_d = proto_pkg::ST_BAD_SUM;
        end else begin
            case (frame_cmd_i)
                proto_pkg::CMD_PWM_DUTY: begin
                    if (frame_payload_i.duty_cfg.channel < 8'(pwm_pkg::N_CH)) begin
                        we_d = 1'b1;
                    end else begin
                        status_d = proto_pkg::ST_BAD_CMD;
                    end
                end
                proto_pkg::CMD_PWM_PERIOD: begin
                    we_d  = 1'b1;
                    // sel high picks the period registers
                    sel_d = 1'b1;
                end
                proto_pkg::CMD_STATUS: begin
                    status_d = lost_cnt;
                    stat_rd  = 1'b1;
                end
                default: begin
                    status_d = proto_pkg::ST_BAD_CMD;
                end
            endcase
        end
    end

    // ========================================================================
    // registered strobes toward pwm bank and framer
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            cfg_we_o   <= 1'b0;
            rsp_push_o <= 1'b0;
        end else begin
            cfg_we_o   <= frame_valid_i && we_d;
            rsp_push_o <= frame_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_valid_i) begin
            cfg_sel_o     <= sel_d;
            cfg_payload_o <= frame_payload_i;
            rsp_cmd_o     <= frame_cmd_i;
            rsp_status_o  <= status_d;
        end
    end

    // reply lost when the queue is full at push time
    assign drop = rsp_push_o && rsp_full_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            lost_cnt <= 8'd0;
        end else if (frame_valid_i && stat_rd) begin
            // read clears, a drop in the same cycle still counts
            lost_cnt <= drop ? 8'd1 : 8'd0;
        end else if (drop && lost_cnt != 8'hFF) begin
            lost_cnt <= lost_cnt + 8'd1;
        end
    end

endmodule

//--- pwm_bank.sv
`timescale 1ns/1ps

module pwm_bank (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    cfg_we_i,
    input  logic                    cfg_sel_i,
    input  proto_pkg::cmd_payload_u cfg_payload_i,
    output logic [pwm_pkg::N_CH-1:0] pwm_o
);

    logic [pwm_pkg::PRE_W-1:0] pre_sh, pre_act, pre_cnt;
    logic [pwm_pkg::CNT_W-1:0] per_sh, per_act, cnt;
    logic [pwm_pkg::CNT_W-1:0] duty_sh  [pwm_pkg::N_CH];
    logic [pwm_pkg::CNT_W-1:0] duty_act [pwm_pkg::N_CH];
    logic                      tick;
    logic                      wrap;

    assign tick = (pre_cnt == pre_act);
    assign wrap = tick && (cnt == per_act);

    // ========================================================================
    // shadow writes, copied to active at the period wrap
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pre_sh  <= '0;
            pre_act <= '0;
            per_sh  <= '1;
            per_act <= '1;
            for (int k = 0; k < pwm_pkg::N_CH; k++) begin
                duty_sh[k]  <= '0;
                duty_act[k] <= '0;
            end
        end else begin
            if (cfg_we_i && cfg_sel_i) begin
                pre_sh <= cfg_payload_i.period_cfg.prescale;
                per_sh <= cfg_payload_i.period_cfg.period;
            end
            for (int k = 0; k < pwm_pkg::N_CH; k++) begin
                if (cfg_we_i && !cfg_sel_i && cfg_payload_i.duty_cfg.channel == 8'(k)) begin
                    duty_sh[k] <= cfg_payload_i.duty_cfg.duty;
                end
            end
            if (wrap) begin
                pre_act  <= pre_sh;
                per_act  <= per_sh;
                duty_act <= duty_sh;
            end
        end
    end

    // prescaled period counter and comparators
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pre_cnt <= '0;
            cnt     <= '0;
            pwm_o   <= '0;
        end else begin
            pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
            if (tick) begin
                cnt <= wrap ? '0 : cnt + 1'b1;
            end
            for (int k = 0; k < pwm_pkg::N_CH; k++) begin
                pwm_o[k] <= (cnt < duty_act[k]);
            end
        end
    end

endmodule

//--- upload_framer.sv
`timescale 1ns/1ps

module upload_framer (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       rsp_push_i,
    input  logic [7:0] rsp_cmd_i,
    input  logic [7:0] rsp_status_i,
    input  logic       upload_afull_i,
    output logic       rsp_full_o,
    output logic [7:0] upload_data_o,
    output logic       upload_valid_o
);

    logic [7:0]                    q_cmd [proto_pkg::RSP_DEPTH];
    logic [7:0]                    q_st  [proto_pkg::RSP_DEPTH];
    logic [proto_pkg::RSP_PTR_W-1:0] wr_ptr, rd_ptr;
    logic [proto_pkg::RSP_PTR_W:0]   count;
    logic [1:0]                    byte_idx;
    logic                          push_ok;
    logic                          last_byte;

    assign rsp_full_o = (count == (proto_pkg::RSP_PTR_W + 1)'(proto_pkg::RSP_DEPTH));
    assign push_ok    = rsp_push_i && !rsp_full_o;

    // ========================================================================
    // serializer reads straight from the queue head
    // ========================================================================
    assign upload_valid_o = (count != '0) && !upload_afull_i;
    // fourth byte closes the reply
    assign last_byte      = upload_valid_o && (byte_idx == 2'd3);

    always_comb begin
        case (byte_idx)
            2'd0:    upload_data_o = proto_pkg::RSP_SOF_BYTE;
            2'd1:    upload_data_o = q_cmd[rd_ptr];
            2'd2:    upload_data_o = q_st[rd_ptr];
            default: upload_data_o = q_cmd[rd_ptr] ^ q_st[rd_ptr];
        endcase
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            q_cmd[wr_ptr] <= rsp_cmd_i;
            q_st[wr_ptr]  <= rsp_status_i;
        end
    end

    // ========================================================================
    // queue pointers and byte index
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            byte_idx <= 2'd0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (upload_valid_o) begin
                byte_idx <= byte_idx + 2'd1;
            end
            if (last_byte) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, last_byte})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- cdc_ctrl_top.sv
`timescale 1ns/1ps

module cdc_ctrl_top (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic [7:0]               usb_data_i,
    input  logic                     usb_data_valid_i,
    input  logic                     upload_afull_i,
    output logic [7:0]               upload_data_o,
    output logic                     upload_valid_o,
    output logic [pwm_pkg::N_CH-1:0] pwm_o
);

    // ========================================================================
    // parser to dispatcher
    // ========================================================================
    logic                    frame_valid;
    logic [7:0]              frame_cmd;
    proto_pkg::cmd_payload_u frame_payload;
    logic                    frame_sum_ok;

    // dispatcher to pwm bank
    logic                    cfg_we;
    logic                    cfg_sel;
    proto_pkg::cmd_payload_u cfg_payload;

    // dispatcher to framer
    logic                    rsp_push;
    logic [7:0]              rsp_cmd;
    logic [7:0]              rsp_status;
    logic                    rsp_full;

    cmd_frame_parser u_parser (
        .clk              (clk),
        .rst_i            (rst_i),
        .usb_data_i       (usb_data_i),
        .usb_data_valid_i (usb_data_valid_i),
        .frame_valid_o    (frame_valid),
        .frame_cmd_o      (frame_cmd),
        .frame_payload_o  (frame_payload),
        .frame_sum_ok_o   (frame_sum_ok)
    );

    cmd_dispatch u_dispatch (
        .clk             (clk),
        .rst_i           (rst_i),
        .frame_valid_i   (frame_valid),
        .frame_cmd_i     (frame_cmd),
        .frame_payload_i (frame_payload),
        .frame_sum_ok_i  (frame_sum_ok),
        .rsp_full_i      (rsp_full),
        .cfg_we_o        (cfg_we),
        .cfg_sel_o       (cfg_sel),
        .cfg_payload_o   (cfg_payload),
        .rsp_push_o      (rsp_push),
        .rsp_cmd_o       (rsp_cmd),
        .rsp_status_o    (rsp_status)
    );

    pwm_bank u_pwm (
        .clk           (clk),
        .rst_i         (rst_i),
        .cfg_we_i      (cfg_we),
        .cfg_sel_i     (cfg_sel),
        .cfg_payload_i (cfg_payload),
        .pwm_o         (pwm_o)
    );

    upload_framer u_framer (
        .clk            (clk),
        .rst_i          (rst_i),
        .rsp_push_i     (rsp_push),
        .rsp_cmd_i      (rsp_cmd),
        .rsp_status_i   (rsp_status),
        .upload_afull_i (upload_afull_i),
        .rsp_full_o     (rsp_full),
        .upload_data_o  (upload_data_o),
        .upload_valid_o (upload_valid_o)
    );

endmodule

//--- cdc_ctrl_checker.sv
`timescale 1ns/1ps

module cdc_ctrl_checker (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     upload_afull_i,
    input  logic                     upload_valid_i,
    input  logic [7:0]               upload_data_i,
    input  logic [pwm_pkg::N_CH-1:0] pwm_i
);

    // set by any failing assertion
    logic err_flag;

    initial begin
        err_flag = 1'b0;
    end

    // ========================================================================
    // upload stream against the reply model
    // ========================================================================
    a_reply_byte: assert property (@(posedge clk) disable iff (rst_i)
        upload_valid_i |-> upload_data_i == tb_cdc_ctrl.exp_byte)
    else begin
        $error("FAIL t=%0t upload_data_o got %02h exp %02h", $time,
               $sampled(upload_data_i), $sampled(tb_cdc_ctrl.exp_byte));
        err_flag = 1'b1;
    end

    // no byte beyond the expected replies
    a_no_extra: assert property (@(posedge clk) disable iff (rst_i)
        upload_valid_i |-> tb_cdc_ctrl.exp_pending != 0)
    else begin
        $error("FAIL t=%0t upload_valid_o got 1 exp 0", $time);
        err_flag = 1'b1;
    end

    a_afull: assert property (@(posedge clk)
        upload_afull_i |-> !upload_valid_i)
    else begin
        $error("FAIL t=%0t upload_valid_o got 1 exp 0 under upload_afull_i", $time);
        err_flag = 1'b1;
    end

    // ========================================================================
    // reset state and pwm high time
    // ========================================================================
    a_rst_valid: assert property (@(posedge clk)
        tb_cdc_ctrl.boot_done && !tb_cdc_ctrl.frame_sent |-> !upload_valid_i)
    else begin
        $error("FAIL t=%0t upload_valid_o got %b exp 0", $time, $sampled(upload_valid_i));
        err_flag = 1'b1;
    end

    a_rst_pwm: assert property (@(posedge clk)
        tb_cdc_ctrl.boot_done && !tb_cdc_ctrl.frame_sent |-> pwm_i == '0)
    else begin
        $error("FAIL t=%0t pwm_o got %02h exp 00", $time, $sampled(pwm_i));
        err_flag = 1'b1;
    end

    for (genvar k = 0; k < pwm_pkg::N_CH; k++) begin : g_pwm
        a_pwm_high: assert property (@(posedge clk) disable iff (rst_i)
            tb_cdc_ctrl.meas_done |-> tb_cdc_ctrl.meas_high[k] == tb_cdc_ctrl.exp_high[k])
        else begin
            $error("FAIL t=%0t pwm_o[%0d] high cycles got %0d exp %0d", $time, k,
                   $sampled(tb_cdc_ctrl.meas_high[k]), $sampled(tb_cdc_ctrl.exp_high[k]));
            err_flag = 1'b1;
        end
    end

endmodule

//--- tb_cdc_ctrl.sv
`timescale 1ns/1ps

module tb_cdc_ctrl;

    localparam int DRAIN_TIMEOUT = 400;

    logic                     clk;
    logic                     rst_i;
    logic [7:0]               usb_data_i;
    logic                     usb_data_valid_i;
    logic                     upload_afull_i;
    logic [7:0]               upload_data_o;
    logic                     upload_valid_o;
    logic [pwm_pkg::N_CH-1:0] pwm_o;

    // reference model state, read by the bound checker
    logic [7:0]  exp_byte;
    int          exp_pending;
    logic        boot_done;
    logic        frame_sent;
    logic        meas_done;
    int          meas_high [pwm_pkg::N_CH];
    int          exp_high  [pwm_pkg::N_CH];

    logic [7:0]  exp_cmd_q [$];
    logic [7:0]  exp_st_q  [$];
    int          sink_idx;
    int          exp_lost;
    int          exp_pre;
    int          exp_per;
    int          exp_duty [pwm_pkg::N_CH];
    logic        hold_afull;
    int          burst_left;
    logic [31:0] sink_rnd;
    logic [31:0] seed;
    logic [31:0] sink_seed;

    cdc_ctrl_top dut (
        .clk              (clk),
        .rst_i            (rst_i),
        .usb_data_i       (usb_data_i),
        .usb_data_valid_i (usb_data_valid_i),
        .upload_afull_i   (upload_afull_i),
        .upload_data_o    (upload_data_o),
        .upload_valid_o   (upload_valid_o),
        .pwm_o            (pwm_o)
    );

    bind cdc_ctrl_top cdc_ctrl_checker u_chk (
        .clk            (clk),
        .rst_i          (rst_i),
        .upload_afull_i (upload_afull_i),
        .upload_valid_i (upload_valid_o),
        .upload_data_i  (upload_data_o),
        .pwm_i          (pwm_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // separate state per caller keeps the streams independent of process order
    function automatic logic [31:0] next_rand(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    // next expected upload byte from the reply at the queue head
    function automatic void refresh_exp();
        exp_pending = exp_cmd_q.size();
        if (exp_pending == 0) begin
            exp_byte = 8'h00;
        end else begin
            case (sink_idx)
                0:       exp_byte = proto_pkg::RSP_SOF_BYTE;
                1:       exp_byte = exp_cmd_q[0];
                2:       exp_byte = exp_st_q[0];
                default: exp_byte = exp_cmd_q[0] ^ exp_st_q[0];
            endcase
        end
    endfunction

    task automatic send_byte(input logic [7:0] b);
        int gap;
        @(negedge clk);
        usb_data_i       = b;
        usb_data_valid_i = 1'b1;
        gap = int'(next_rand(seed) >> 29) % 3;
        repeat (gap) begin
            @(negedge clk);
            usb_data_valid_i = 1'b0;
        end
    endtask

    task automatic send_frame(input logic [7:0] cmd, input logic [23:0] pl,
                              input logic bad_sum, input int garbage);
        logic [7:0] sum;
        logic [7:0] st;
        logic [7:0] g;
        frame_sent = 1'b1;
        for (int i = 0; i < garbage; i++) begin
            g = 8'(next_rand(seed) >> 8);
            if (g == proto_pkg::SOF_BYTE) begin
                g = 8'h00;
            end
            send_byte(g);
        end
        sum = cmd ^ pl[23:16] ^ pl[15:8] ^ pl[7:0];
        if (bad_sum) begin
            sum = ~sum;
            st  = proto_pkg::ST_BAD_SUM;
        end else if (cmd == proto_pkg::CMD_PWM_DUTY && pl[23:16] < 8'(pwm_pkg::N_CH)) begin
            st = proto_pkg::ST_OK;
            exp_duty[pl[18:16]] = int'(pl[15:0]);
        end else if (cmd == proto_pkg::CMD_PWM_PERIOD) begin
            st      = proto_pkg::ST_OK;
            exp_pre = int'(pl[23:16]);
            exp_per = int'(pl[15:0]);
        end else if (cmd == proto_pkg::CMD_STATUS) begin
            st       = 8'(exp_lost);
            exp_lost = 0;
        end else begin
            st = proto_pkg::ST_BAD_CMD;
        end
        // a full reply queue drops the reply
        if (exp_cmd_q.size() >= proto_pkg::RSP_DEPTH) begin
            if (exp_lost < 255) begin
                exp_lost++;
            end
        end else begin
            exp_cmd_q.push_back(cmd);
            exp_st_q.push_back(st);
        end
        refresh_exp();
        send_byte(proto_pkg::SOF_BYTE);
        send_byte(cmd);
        send_byte(pl[23:16]);
        send_byte(pl[15:8]);
        send_byte(pl[7:0]);
        send_byte(sum);
        @(negedge clk);
        usb_data_valid_i = 1'b0;
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while (exp_pending != 0) begin
            @(negedge clk);
            t++;
            if (t > DRAIN_TIMEOUT) begin
                $display("TEST FAILED");
                $fatal(1, "timeout waiting for the expected replies on the upload stream");
            end
        end
    endtask

    // one full period in steady state holds (pre+1)*min(d, per+1) high cycles
    task automatic measure_pwm();
        int win;
        win = (exp_pre + 1) * (exp_per + 1);
        for (int k = 0; k < pwm_pkg::N_CH; k++) begin
            meas_high[k] = 0;
            exp_high[k]  = (exp_pre + 1)
                           * ((exp_duty[k] < exp_per + 1) ? exp_duty[k] : exp_per + 1);
        end
        repeat (win) begin
            @(posedge clk);
            for (int k = 0; k < pwm_pkg::N_CH; k++) begin
                meas_high[k] += int'(pwm_o[k]);
            end
        end
        @(negedge clk);
        meas_done = 1'b1;
        @(negedge clk);
        meas_done = 1'b0;
    endtask

    // ========================================================================
    // upload sink with random almost-full bursts
    // ========================================================================
    always @(negedge clk) begin
        if (hold_afull) begin
            upload_afull_i = 1'b1;
        end else if (burst_left == 0) begin
            sink_rnd       = next_rand(sink_seed);
            // mostly open
            upload_afull_i = (sink_rnd[31:30] == 2'b11);
            burst_left     = int'(sink_rnd[18:16]) + 1;
        end else begin
            burst_left--;
        end
    end

    always @(posedge clk) begin
        if (upload_valid_o && exp_pending != 0) begin
            if (sink_idx == 3) begin
                void'(exp_cmd_q.pop_front());
                void'(exp_st_q.pop_front());
                sink_idx = 0;
            end else begin
                sink_idx++;
            end
            refresh_exp();
        end
    end

    always @(negedge clk) begin
        if (dut.u_chk.err_flag) begin
            $display("TEST FAILED");
            $fatal(1, "a checker assertion failed");
        end
    end

    // ========================================================================
    // test sequence
    // ========================================================================
    initial begin
        seed             = 32'hf113;
        sink_seed        = 32'hf113;
        rst_i            = 1'b1;
        usb_data_i       = 8'h00;
        usb_data_valid_i = 1'b0;
        upload_afull_i   = 1'b0;
        hold_afull       = 1'b0;
        burst_left       = 0;
        sink_idx         = 0;
        exp_lost         = 0;
        exp_pre          = 0;
        exp_per          = 32'hFFFF;
        boot_done        = 1'b0;
        frame_sent       = 1'b0;
        meas_done        = 1'b0;
        for (int k = 0; k < pwm_pkg::N_CH; k++) begin
            exp_duty[k]  = 0;
            meas_high[k] = 0;
            exp_high[k]  = 0;
        end
        refresh_exp();
        @(negedge clk);
        boot_done = 1'b1;
        repeat (4) @(negedge clk);
        rst_i = 1'b0;
        repeat (10) @(negedge clk);

        // replies in order, frames behind garbage bytes
        for (int i = 0; i < 6; i++) begin
            send_frame((i % 2 == 1) ? proto_pkg::CMD_STATUS : 8'h40 + 8'(i),
                       24'(next_rand(seed)), 1'b0, i % 4);
            wait_drained();
        end

        // 20 cycle period, prescale 1 and period 9
        send_frame(proto_pkg::CMD_PWM_PERIOD, {8'd1, 16'd9}, 1'b0, 0);
        wait_drained();
        // reset period of 65536 cycles has to wrap first
        repeat (65600) @(negedge clk);
        send_frame(proto_pkg::CMD_PWM_DUTY, {8'd2, 16'd4}, 1'b0, 1);
        wait_drained();
        send_frame(proto_pkg::CMD_PWM_DUTY, {8'd5, 16'd30}, 1'b0, 0);
        wait_drained();
        send_frame(proto_pkg::CMD_PWM_DUTY, {8'd0, 16'd0}, 1'b0, 2);
        wait_drained();
        repeat (60) @(negedge clk);
        measure_pwm();

        // bad checksum, bad channel, unknown command
        send_frame(proto_pkg::CMD_PWM_DUTY, {8'd3, 16'd7}, 1'b1, 0);
        wait_drained();
        send_frame(proto_pkg::CMD_PWM_DUTY, {8'd9, 16'd7}, 1'b0, 0);
        wait_drained();
        send_frame(proto_pkg::CMD_PWM_PERIOD, {8'd0, 16'd3}, 1'b1, 0);
        wait_drained();
        send_frame(8'h42, 24'h123456, 1'b0, 0);
        wait_drained();
        repeat (60) @(negedge clk);
        measure_pwm();

        // seven frames under almost-full, queue takes four
        hold_afull = 1'b1;
        repeat (2) @(negedge clk);
        for (int i = 0; i < 7; i++) begin
            send_frame(8'h60 + 8'(i), 24'h000000, 1'b0, 0);
        end
        repeat (10) @(negedge clk);
        hold_afull = 1'b0;
        wait_drained();
        send_frame(proto_pkg::CMD_STATUS, 24'h000000, 1'b0, 0);
        wait_drained();
        send_frame(proto_pkg::CMD_STATUS, 24'h000000, 1'b0, 0);
        wait_drained();

        repeat (20) @(negedge clk);
        if (dut.u_chk.err_flag) begin
            $display("TEST FAILED");
            $fatal(1, "a checker assertion failed");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- compile.f
proto_pkg.sv
pwm_pkg.sv
cmd_frame_parser.sv
cmd_dispatch.sv
pwm_bank.sv
upload_framer.sv
cdc_ctrl_top.sv
cdc_ctrl_checker.sv
tb_cdc_ctrl.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_cdc_ctrl -f compile.f -o tb_cdc_ctrl_sim

./obj_dir/tb_cdc_ctrl_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST PASSED" sim.log; then
    echo "simulation ok"
else
    echo "simulation reported a failure"
    exit 1
fi
